//--- Bender.yml
package:
  name: check_node_update

sources:
  - hdl/ldpc_types_pkg.sv
  - hdl/ldpc_timing_pkg.sv
  - hdl/min_search.sv
  - hdl/edge_lane.sv
  - hdl/check_node_state.sv
  - hdl/check_node_update.sv
  - target: test
    files:
      - sim/tb_check_node_update.sv

//--- hdl/check_node_state.sv
/*
 * Shared check node state: sign parity over all edges, alignment of the
 * first minimum to the second search, and the valid pipeline.
 */

`timescale 1ns/10ps

`default_nettype none

module check_node_state
    import ldpc_types_pkg::*;
    import ldpc_timing_pkg::*;
(
    input  wire logic                  i_clock,
    input  wire logic                  i_reset,
    input  wire logic                  i_valid,
    input  wire logic [EDGE_COUNT-1:0] i_signs,
    input  wire mag_t                  i_first_min,
    input  wire edge_mask_t            i_location,
    output      mag_t                  o_first_min,
    output      edge_mask_t            o_location,
    output      logic                  o_parity,
    output      logic                  o_valid
);

    // Parity is registered one cycle after the split, then waits for both searches
    localparam int PARITY_DELAY = 2 * MIN_SEARCH_LATENCY + MASK_LATENCY;
    // First minimum waits for the mask stage and the second search
    localparam int FIRST_MIN_DELAY = MASK_LATENCY + MIN_SEARCH_LATENCY;

    logic [SEARCH_SLOTS-1:0]       sign_pad;
    logic                          parity_low;
    logic                          parity_high;
    logic [PARITY_DELAY-1:0]       parity_pipe;
    mag_t                          first_min_pipe [FIRST_MIN_DELAY];
    logic [CHECK_NODE_LATENCY-1:0] valid_pipe;

    // Two level XOR tree, pad bits are zero
    assign sign_pad = {{(SEARCH_SLOTS - EDGE_COUNT){1'b0}}, i_signs};
    assign parity_low = ^sign_pad[SEARCH_SLOTS/2-1:0];
    assign parity_high = ^sign_pad[SEARCH_SLOTS-1:SEARCH_SLOTS/2];

    always_ff @(posedge i_clock) begin
        parity_pipe <= {parity_pipe[PARITY_DELAY-2:0], parity_low ^ parity_high};
    end

    always_ff @(posedge i_clock) begin
        first_min_pipe[0] <= i_first_min;
        for (int i = 1; i < FIRST_MIN_DELAY; i++) begin
            first_min_pipe[i] <= first_min_pipe[i-1];
        end
    end

    assign o_first_min = first_min_pipe[FIRST_MIN_DELAY-1];
    assign o_parity = parity_pipe[PARITY_DELAY-1];

    // Broadcast straight away, the lanes mask on it in the next cycle
    assign o_location = i_location;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[CHECK_NODE_LATENCY-2:0], i_valid};
        end
    end

    assign o_valid = valid_pipe[CHECK_NODE_LATENCY-1];

    // Every output strobe traces back to an input strobe at the fixed latency
    a_valid_latency: assert property (
        @(posedge i_clock) disable iff (i_reset)
        o_valid |-> $past(i_valid, CHECK_NODE_LATENCY)
    );

endmodule : check_node_state

`default_nettype wire

//--- hdl/check_node_update.sv
/*
 * Min-sum check node update for seven edges, top level.
 * Takes one LLR vector per cycle with i_valid; results follow on o_llrs
 * with o_valid at a fixed latency, without back-pressure.
 */

`timescale 1ns/10ps

`default_nettype none

module check_node_update
    import ldpc_types_pkg::*;
(
    input  wire logic       i_clock,
    input  wire logic       i_reset,
    input  wire llr_array_t i_llrs,
    input  wire logic       i_valid,
    output wire llr_array_t o_llrs,
    output      logic       o_valid
);

    wire mag_array_t            magnitudes;
    wire mag_array_t            masked_magnitudes;
    wire logic [EDGE_COUNT-1:0] signs;
    mag_t                       first_min;
    edge_mask_t                 first_location;
    mag_t                       aligned_first_min;
    edge_mask_t                 location;
    logic                       parity;
    mag_t                       second_min;

    for (genvar e = 0; e < EDGE_COUNT; e++) begin : g_lane
        edge_lane i_edge_lane (
            .i_clock            (i_clock),
            .i_reset            (i_reset),
            .i_llr              (i_llrs[e]),
            .i_is_min           (location[e]),
            .i_first_min        (aligned_first_min),
            .i_second_min       (second_min),
            .i_parity           (parity),
            .o_magnitude        (magnitudes[e]),
            .o_masked_magnitude (masked_magnitudes[e]),
            .o_sign             (signs[e]),
            .o_llr              (o_llrs[e])
        );
    end

    // First minimum and where it sits
    min_search i_min_search_first (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_magnitudes (magnitudes),
        .o_minimum    (first_min),
        .o_location   (first_location)
    );

    // Runner-up, with the first minimum masked out
    min_search i_min_search_second (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_magnitudes (masked_magnitudes),
        .o_minimum    (second_min),
        .o_location   ()
    );

    check_node_state i_check_node_state (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_valid     (i_valid),
        .i_signs     (signs),
        .i_first_min (first_min),
        .i_location  (first_location),
        .o_first_min (aligned_first_min),
        .o_location  (location),
        .o_parity    (parity),
        .o_valid     (o_valid)
    );

endmodule : check_node_update

`default_nettype wire

//--- hdl/edge_lane.sv
/*
 * One edge of the check node: magnitude and sign split, masking of the
 * first minimum for the second search, and the signed output select.
 * Instantiated once per edge by the check node top level.
 */

`timescale 1ns/10ps

`default_nettype none

module edge_lane
    import ldpc_types_pkg::*;
    import ldpc_timing_pkg::*;
(
    input  wire logic i_clock,
    input  wire logic i_reset,
    input  wire llr_t i_llr,
    input  wire logic i_is_min,
    input  wire mag_t i_first_min,
    input  wire mag_t i_second_min,
    input  wire logic i_parity,
    output      mag_t o_magnitude,
    output      mag_t o_masked_magnitude,
    output      logic o_sign,
    output      llr_t o_llr
);

    // Magnitude waits for the first search result
    localparam int MAG_DELAY = MIN_SEARCH_LATENCY;
    // Location flag rides along with the mask and the second search
    localparam int IS_MIN_DELAY = MASK_LATENCY + MIN_SEARCH_LATENCY;
    // Sign waits for both searches and the mask stage
    localparam int SIGN_DELAY = 2 * MIN_SEARCH_LATENCY + MASK_LATENCY;

    mag_t                    neg_mag;
    mag_t                    split_mag;
    mag_t                    mag_pipe [MAG_DELAY];
    logic [IS_MIN_DELAY-1:0] is_min_pipe;
    logic [SIGN_DELAY-1:0]   sign_pipe;
    mag_t                    out_mag;
    logic                    out_negate;

    // -128 wraps to 128 when negated, saturate it to 127
    assign neg_mag = mag_t'(-i_llr);

    always_comb begin
        if (i_llr[LLR_WIDTH-1]) begin
            split_mag = (neg_mag > MAG_MAX) ? MAG_MAX : neg_mag;
        end else begin
            split_mag = mag_t'(i_llr);
        end
    end

    always_ff @(posedge i_clock) begin
        o_magnitude <= split_mag;
        o_sign <= i_llr[LLR_WIDTH-1];
    end

    always_ff @(posedge i_clock) begin
        mag_pipe[0] <= o_magnitude;
        for (int i = 1; i < MAG_DELAY; i++) begin
            mag_pipe[i] <= mag_pipe[i-1];
        end
    end

    // Hide the first minimum so the second search finds the runner-up
    always_ff @(posedge i_clock) begin
        o_masked_magnitude <= i_is_min ? MAG_MASKED : mag_pipe[MAG_DELAY-1];
        is_min_pipe <= {is_min_pipe[IS_MIN_DELAY-2:0], i_is_min};
        sign_pipe <= {sign_pipe[SIGN_DELAY-2:0], o_sign};
    end

    // The edge holding the first minimum gets the second one
    assign out_mag = is_min_pipe[IS_MIN_DELAY-1] ? i_second_min : i_first_min;

    // Own sign removed from the total parity
    assign out_negate = sign_pipe[SIGN_DELAY-1] ^ i_parity;

    always_ff @(posedge i_clock) begin
        if (out_negate) begin
            o_llr <= llr_t'(-out_mag);
        end else begin
            o_llr <= llr_t'(out_mag);
        end
    end

    // Saturation keeps every magnitude, and so every output, representable
    a_magnitude_saturated: assert property (
        @(posedge i_clock) disable iff (i_reset)
        !$isunknown(o_magnitude) |-> o_magnitude <= MAG_MAX
    );

endmodule : edge_lane

`default_nettype wire

//--- hdl/ldpc_timing_pkg.sv
/*
 * Pipeline latencies of the check node stages, in clock cycles.
 * Delay lines in the RTL are sized from these so the stages line up.
 */
package ldpc_timing_pkg;

    // LLR to magnitude and sign
    localparam int SPLIT_LATENCY = 1;

    // One register per comparator tree level
    localparam int MIN_SEARCH_LATENCY = 3;

    // Hiding the first minimum from the second search
    localparam int MASK_LATENCY = 1;

    // Signed output select
    localparam int OUTPUT_LATENCY = 1;

    // Input sample to o_valid, along the two searches
    localparam int CHECK_NODE_LATENCY = SPLIT_LATENCY + 2 * MIN_SEARCH_LATENCY
                                      + MASK_LATENCY + OUTPUT_LATENCY;

endpackage

//--- hdl/ldpc_types_pkg.sv
/*
 * Widths, constants and data types of the min-sum check node.
 * Imported by every RTL module and by the testbench.
 */
package ldpc_types_pkg;

    localparam int LLR_WIDTH = 8;
    localparam int EDGE_COUNT = 7;

    // Comparator tree slots, edges padded up to a power of two
    localparam int SEARCH_SLOTS = 2 ** $clog2(EDGE_COUNT);

    typedef logic signed [LLR_WIDTH-1:0] llr_t;
    typedef logic [LLR_WIDTH-1:0] mag_t;
    typedef logic [EDGE_COUNT-1:0] edge_mask_t;

    // One entry per edge, edge 0 in the lowest bits
    typedef mag_t [EDGE_COUNT-1:0] mag_array_t;
    typedef llr_t [EDGE_COUNT-1:0] llr_array_t;

    // Largest magnitude after saturation of the most negative LLR
    localparam mag_t MAG_MAX = mag_t'(2 ** (LLR_WIDTH - 1) - 1);

    // Pad and mask value, above any real magnitude
    localparam mag_t MAG_MASKED = '1;

endpackage

//--- hdl/min_search.sv
/*
 * Pipelined comparator tree over the edge magnitudes.
 * Returns the smallest magnitude and its one-hot edge, one level per cycle.
 */

`timescale 1ns/10ps

`default_nettype none

module min_search
    import ldpc_types_pkg::*;
    import ldpc_timing_pkg::*;
(
    input  wire logic       i_clock,
    input  wire logic       i_reset,
    input  wire mag_array_t i_magnitudes,
    output      mag_t       o_minimum,
    output      edge_mask_t o_location
);

    localparam int HALF_SLOTS = SEARCH_SLOTS / 2;

    mag_t                    slot_mag [SEARCH_SLOTS];
    logic [SEARCH_SLOTS-1:0] slot_loc [SEARCH_SLOTS];

    // Tree levels 1 to MIN_SEARCH_LATENCY, level n holds SEARCH_SLOTS >> n nodes
    mag_t                    tree_mag [1:MIN_SEARCH_LATENCY][HALF_SLOTS];
    logic [SEARCH_SLOTS-1:0] tree_loc [1:MIN_SEARCH_LATENCY][HALF_SLOTS];

    // Real edges first, then pads that never win against a real magnitude
    always_comb begin
        for (int s = 0; s < EDGE_COUNT; s++) begin
            slot_mag[s] = i_magnitudes[s];
        end
        for (int s = EDGE_COUNT; s < SEARCH_SLOTS; s++) begin
            slot_mag[s] = MAG_MASKED;
        end
        for (int s = 0; s < SEARCH_SLOTS; s++) begin
            slot_loc[s] = SEARCH_SLOTS'(1) << s;
        end
    end

    // Strict compare keeps the lower slot on a tie
    always_ff @(posedge i_clock) begin
        for (int n = 0; n < HALF_SLOTS; n++) begin
            if (slot_mag[2*n+1] < slot_mag[2*n]) begin
                tree_mag[1][n] <= slot_mag[2*n+1];
                tree_loc[1][n] <= slot_loc[2*n+1];
            end else begin
                tree_mag[1][n] <= slot_mag[2*n];
                tree_loc[1][n] <= slot_loc[2*n];
            end
        end

        for (int lvl = 2; lvl <= MIN_SEARCH_LATENCY; lvl++) begin
            for (int n = 0; n < (SEARCH_SLOTS >> lvl); n++) begin
                if (tree_mag[lvl-1][2*n+1] < tree_mag[lvl-1][2*n]) begin
                    tree_mag[lvl][n] <= tree_mag[lvl-1][2*n+1];
                    tree_loc[lvl][n] <= tree_loc[lvl-1][2*n+1];
                end else begin
                    tree_mag[lvl][n] <= tree_mag[lvl-1][2*n];
                    tree_loc[lvl][n] <= tree_loc[lvl-1][2*n];
                end
            end
        end
    end

    assign o_minimum = tree_mag[MIN_SEARCH_LATENCY][0];

    // Pad slots can only win if every edge is masked, so drop their bits
    assign o_location = tree_loc[MIN_SEARCH_LATENCY][0][EDGE_COUNT-1:0];

    // Exactly one edge holds the minimum once the tree carries real data
    a_location_onehot: assert property (
        @(posedge i_clock) disable iff (i_reset)
        !$isunknown(o_location) |-> $onehot(o_location)
    );

endmodule : min_search

`default_nettype wire

//--- sim/tb_check_node_update.sv
/*
 * Directed testbench for the min-sum check node update.
 * A reference model queues the expected vector for every accepted input and
 * a monitor compares each o_valid output against it.
 */

`timescale 1ns/10ps

module tb_check_node_update
    import ldpc_types_pkg::*;
    import ldpc_timing_pkg::*;
();

    localparam int DRAIN_TIMEOUT = 4 * CHECK_NODE_LATENCY;
    localparam llr_t LLR_MOST_NEGATIVE = llr_t'(1 << (LLR_WIDTH - 1));

    logic       i_clock = 1'b0;
    logic       i_reset;
    llr_array_t i_llrs;
    logic       i_valid;
    llr_array_t o_llrs;
    logic       o_valid;

    llr_array_t  expected_q [$];
    string       current_test = "none";
    int          mismatch_count = 0;
    int          other_errors = 0;
    int          sent_count = 0;
    int          received_count = 0;
    logic [31:0] lfsr_state = 32'h1a5b_b1df;

    check_node_update i_check_node_update (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_llrs  (i_llrs),
        .i_valid (i_valid),
        .o_llrs  (o_llrs),
        .o_valid (o_valid)
    );

    always #50 i_clock = ~i_clock;

    // Feedback from taps 32, 22, 2 and 1 on every step
    function automatic logic [31:0] lfsr_bits(input int count);
        logic        feedback;
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            bits = {bits[30:0], feedback};
        end
        return bits;
    endfunction

    function automatic llr_array_t random_vector();
        llr_array_t v;
        for (int e = 0; e < EDGE_COUNT; e++) begin
            v[e] = llr_t'(lfsr_bits(LLR_WIDTH));
        end
        return v;
    endfunction

    // Min-sum rule with the smallest other magnitude and the XOR of the other signs
    function automatic llr_array_t expected_outputs(input llr_array_t v);
        int         mag [EDGE_COUNT];
        logic       sign [EDGE_COUNT];
        int         value;
        int         least;
        logic       parity;
        llr_array_t result;
        for (int e = 0; e < EDGE_COUNT; e++) begin
            value = v[e];
            sign[e] = (value < 0);
            mag[e] = (value < 0) ? -value : value;
            if (mag[e] > MAG_MAX) begin
                mag[e] = MAG_MAX;
            end
        end
        for (int e = 0; e < EDGE_COUNT; e++) begin
            least = 1 << LLR_WIDTH;
            parity = 1'b0;
            for (int o = 0; o < EDGE_COUNT; o++) begin
                if (o != e) begin
                    least = (mag[o] < least) ? mag[o] : least;
                    parity = parity ^ sign[o];
                end
            end
            result[e] = llr_t'(parity ? -least : least);
        end
        return result;
    endfunction

    task automatic check_llr(input string name, input llr_t expected, input llr_t actual);
        if (actual !== expected) begin
            $display("mismatch in %s: expected %0d, actual %0d", name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_valid(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("mismatch in %s o_valid: expected %b, actual %b", name, expected, actual);
            mismatch_count++;
        end
    endtask

    // Outputs are sampled on the falling edge where they are stable
    always @(negedge i_clock) begin : monitor
        llr_array_t expected;
        if (!i_reset && o_valid === 1'b1) begin
            if (expected_q.size() == 0) begin
                $display("o_valid high in %s with no input vector pending", current_test);
                other_errors++;
            end else begin
                expected = expected_q.pop_front();
                received_count++;
                for (int e = 0; e < EDGE_COUNT; e++) begin
                    check_llr($sformatf("%s edge %0d", current_test, e), expected[e], o_llrs[e]);
                    if (o_llrs[e] === LLR_MOST_NEGATIVE) begin
                        $display("edge %0d in %s put out the unrepresentable -128", e,
                                 current_test);
                        other_errors++;
                    end
                end
            end
        end
    end

    task automatic wait_cycle();
        @(posedge i_clock);
        #1;
    endtask

    task automatic send_vector(input llr_array_t v);
        i_llrs = v;
        i_valid = 1'b1;
        expected_q.push_back(expected_outputs(v));
        sent_count++;
        wait_cycle();
        i_valid = 1'b0;
    endtask

    // Idle cycles carry junk data that must be ignored
    task automatic idle_cycles(input int count);
        for (int i = 0; i < count; i++) begin
            i_valid = 1'b0;
            i_llrs = random_vector();
            wait_cycle();
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            wait_cycle();
            waited++;
        end
        if (expected_q.size() != 0) begin
            $display("timeout in %s: %0d output vectors never arrived", current_test,
                     expected_q.size());
            other_errors++;
            expected_q.delete();
        end
    endtask

    task automatic test_reset();
        current_test = "reset";
        i_reset = 1'b1;
        for (int cycle = 0; cycle < 4; cycle++) begin
            wait_cycle();
            if (cycle == 3) begin
                i_reset = 1'b0;
            end
            @(negedge i_clock);
            check_valid(current_test, 1'b0, o_valid);
        end
        for (int cycle = 0; cycle < 12; cycle++) begin
            wait_cycle();
            @(negedge i_clock);
            check_valid(current_test, 1'b0, o_valid);
        end
        wait_cycle();
        send_vector(random_vector());
        // A single strobe gives exactly one o_valid cycle at the fixed latency
        for (int cycle = 1; cycle <= CHECK_NODE_LATENCY + 3; cycle++) begin
            @(negedge i_clock);
            check_valid(current_test, cycle == CHECK_NODE_LATENCY, o_valid);
        end
        wait_cycle();
        wait_drain();
    endtask

    task automatic test_mixed_signs();
        llr_array_t v;
        current_test = "mixed signs";
        v[0] = llr_t'(-45);
        v[1] = llr_t'(23);
        v[2] = llr_t'(-9);
        v[3] = llr_t'(70);
        v[4] = llr_t'(31);
        v[5] = llr_t'(-102);
        v[6] = llr_t'(16);
        send_vector(v);
        wait_drain();
    endtask

    // Edges 1 and 3 share the smallest magnitude
    task automatic test_tied_minimum();
        llr_array_t v;
        current_test = "tied minimum";
        v[0] = llr_t'(40);
        v[1] = llr_t'(-12);
        v[2] = llr_t'(90);
        v[3] = llr_t'(12);
        v[4] = llr_t'(-77);
        v[5] = llr_t'(55);
        v[6] = llr_t'(30);
        send_vector(v);
        wait_drain();
    endtask

    task automatic test_saturation();
        llr_array_t v;
        current_test = "saturation";
        v[0] = llr_t'(-128);
        v[1] = llr_t'(127);
        v[2] = llr_t'(-128);
        v[3] = llr_t'(64);
        v[4] = llr_t'(-127);
        v[5] = llr_t'(127);
        v[6] = llr_t'(-100);
        send_vector(v);
        // Six edges at -128 leave edge 3 only saturated magnitudes to pick from
        v[0] = llr_t'(-128);
        v[1] = llr_t'(-128);
        v[2] = llr_t'(-128);
        v[3] = llr_t'(127);
        v[4] = llr_t'(-128);
        v[5] = llr_t'(-128);
        v[6] = llr_t'(-128);
        send_vector(v);
        wait_drain();
    endtask

    task automatic test_streaming();
        current_test = "streaming";
        for (int n = 0; n < 200; n++) begin
            send_vector(random_vector());
        end
        for (int n = 0; n < 200; n++) begin
            idle_cycles(int'(lfsr_bits(2)));
            send_vector(random_vector());
        end
        wait_drain();
    endtask

    initial begin
        i_reset = 1'b1;
        i_valid = 1'b0;
        i_llrs = '0;

        test_reset();
        test_mixed_signs();
        test_tied_minimum();
        test_saturation();
        test_streaming();

        // Let any stray output show up before closing
        idle_cycles(CHECK_NODE_LATENCY + 2);
        if (received_count != sent_count) begin
            $display("sent %0d vectors but received %0d", sent_count, received_count);
            other_errors++;
        end

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule : tb_check_node_update

//--- verilog.f
hdl/ldpc_types_pkg.sv
hdl/ldpc_timing_pkg.sv
hdl/min_search.sv
hdl/edge_lane.sv
hdl/check_node_state.sv
hdl/check_node_update.sv
sim/tb_check_node_update.sv
